// File: common/alloc_pkg.sv
`default_nettype none

package alloc_pkg;

    // router dimensions
    localparam int num_ports = 5;
    localparam int num_vcs = 2;
    localparam int num_ivcs = num_ports * num_vcs;       // same count on the output side

    // no self-loop, so a port targets only the others
    localparam int num_other_ports = num_ports - 1;

    // set of VCs inside one port
    typedef logic [num_vcs-1:0] vc_mask_t;

    // destination set seen from one input port, own port skipped
    typedef logic [num_other_ports-1:0] port_mask_t;

    typedef logic [num_ports-1:0] iport_vec_t;

    // index is port * num_vcs + vc
    typedef logic [num_ivcs-1:0] ivc_vec_t;

    // bit position of out_port in a mask that belongs to in_port
    // ports above the own port shift down by one
    function automatic int rel_index(input int in_port, input int out_port);
        int idx;
        if (out_port > in_port) begin
            idx = out_port - 1;
        end else begin
            idx = out_port;
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

// File: hdl/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int width = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] request,
    input  logic             update,    // grant was used, let the pointer move
    output logic [width-1:0] grant,
    output logic             any_grant
);

    localparam int ptr_w = (width > 1) ? $clog2(width) : 1;

    logic [ptr_w-1:0] ptr;      // index holding top priority
    logic [ptr_w-1:0] winner;

    // first requester at or after ptr, wrapping
    always_comb begin
        grant = '0;
        winner = ptr;
        for (int off = 0; off < width; off++) begin
            if (grant == '0 && request[(int'(ptr) + off) % width]) begin
                grant[(int'(ptr) + off) % width] = 1'b1;
                winner = ptr_w'((int'(ptr) + off) % width);
            end
        end
    end

    assign any_grant = |grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (update && any_grant) begin
            // one past the winner
            if (winner == ptr_w'(width - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= winner + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: vc_alloc/vc_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module vc_alloc
    import alloc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_vec_t   ivc_request,
    input  ivc_vec_t   ovc_is_assigned,
    input  port_mask_t dest_port [num_ivcs],
    input  vc_mask_t   ovc_request [num_ivcs],
    output vc_mask_t   granted_ovc [num_ivcs],
    output ivc_vec_t   ivc_ovc_granted,
    output ivc_vec_t   ovc_allocated
);

    localparam int second_w = num_other_ports * num_vcs;

    vc_mask_t            first_req [num_ivcs];
    vc_mask_t            first_pick [num_ivcs];     // candidate output VC per input VC
    logic [second_w-1:0] second_req [num_ivcs];     // indexed by output VC
    logic [second_w-1:0] second_grant [num_ivcs];

    for (genvar i = 0; i < num_ivcs; i++) begin : g_first
        // head flits only
        assign first_req[i] = (ivc_request[i] && !ovc_is_assigned[i]) ? ovc_request[i] : '0;

        rr_arbiter #(
            .width(num_vcs)
        ) u_first_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (first_req[i]),
            .update   (ivc_ovc_granted[i]),   // hold the pick until it wins
            .grant    (first_pick[i]),
            .any_grant()
        );
    end

    // steer each pick onto the output VC at its destination port
    always_comb begin
        for (int o = 0; o < num_ivcs; o++) begin
            second_req[o] = '0;
            for (int i = 0; i < num_ivcs; i++) begin
                if ((i / num_vcs) != (o / num_vcs)) begin
                    second_req[o][rel_index(o / num_vcs, i / num_vcs) * num_vcs + i % num_vcs] =
                        first_pick[i][o % num_vcs] &
                        dest_port[i][rel_index(i / num_vcs, o / num_vcs)];
                end
            end
        end
    end

    for (genvar o = 0; o < num_ivcs; o++) begin : g_second
        rr_arbiter #(
            .width(second_w)
        ) u_second_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (second_req[o]),
            .update   (1'b1),
            .grant    (second_grant[o]),
            .any_grant(ovc_allocated[o])
        );
    end

    // fold output VC winners back to the input side
    always_comb begin
        for (int i = 0; i < num_ivcs; i++) begin
            granted_ovc[i] = '0;
            for (int o = 0; o < num_ivcs; o++) begin
                if ((o / num_vcs) != (i / num_vcs)) begin
                    granted_ovc[i][o % num_vcs] = granted_ovc[i][o % num_vcs] |
                        second_grant[o][rel_index(o / num_vcs, i / num_vcs) * num_vcs
                                        + i % num_vcs];
                end
            end
        end
    end

    for (genvar i = 0; i < num_ivcs; i++) begin : g_ivc_granted
        assign ivc_ovc_granted[i] = |granted_ovc[i];
    end

endmodule

`default_nettype wire

// File: sw_alloc/sw_alloc_stage.sv
`timescale 1ns/1ps
`default_nettype none

module sw_alloc_stage
    import alloc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_vec_t   ivc_request,
    input  port_mask_t dest_port [num_ivcs],
    output ivc_vec_t   ivc_granted,
    output iport_vec_t inport_granted,
    output port_mask_t granted_dest_port [num_ports],
    output ivc_vec_t   first_stage_ivc
);

    vc_mask_t   in_pick [num_ports];      // input stage winner per port
    port_mask_t port_req [num_ports];     // its destination, relative to the input port
    port_mask_t out_req [num_ports];      // relative to the output port
    port_mask_t out_grant [num_ports];

    for (genvar p = 0; p < num_ports; p++) begin : g_in
        rr_arbiter #(
            .width(num_vcs)
        ) u_in_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (ivc_request[p*num_vcs +: num_vcs]),
            .update   (inport_granted[p]),
            .grant    (in_pick[p]),
            .any_grant()
        );

        assign first_stage_ivc[p*num_vcs +: num_vcs] = in_pick[p];
        assign ivc_granted[p*num_vcs +: num_vcs] = inport_granted[p] ? in_pick[p] : '0;
        assign inport_granted[p] = |granted_dest_port[p];
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            port_req[p] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (in_pick[p][v]) begin
                    port_req[p] = port_req[p] | dest_port[p * num_vcs + v];
                end
            end
        end
    end

    // swap from input-relative to output-relative numbering
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            out_req[o] = '0;
            for (int p = 0; p < num_ports; p++) begin
                if (p != o) begin
                    out_req[o][rel_index(o, p)] = port_req[p][rel_index(p, o)];
                end
            end
        end
    end

    for (genvar o = 0; o < num_ports; o++) begin : g_out
        rr_arbiter #(
            .width(num_other_ports)
        ) u_out_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (out_req[o]),
            .update   (1'b1),
            .grant    (out_grant[o]),
            .any_grant()
        );
    end

    // and back again for the grants
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            granted_dest_port[p] = '0;
            for (int o = 0; o < num_ports; o++) begin
                if (o != p) begin
                    granted_dest_port[p][rel_index(p, o)] = out_grant[o][rel_index(o, p)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sw_alloc/spec_sw_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module spec_sw_alloc
    import alloc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_vec_t   ivc_request,
    input  ivc_vec_t   ovc_is_assigned,
    input  ivc_vec_t   assigned_ovc_not_full,
    input  port_mask_t dest_port [num_ivcs],
    input  ivc_vec_t   ivc_ovc_granted,
    output ivc_vec_t   ivc_sw_granted,
    output port_mask_t granted_dest_port [num_ports],
    output iport_vec_t any_sw_grant
);

    ivc_vec_t   nonspec_req;
    ivc_vec_t   spec_req;
    ivc_vec_t   ns_ivc_granted;
    ivc_vec_t   sp_ivc_granted;
    ivc_vec_t   sp_first;
    iport_vec_t ns_inport_granted;
    iport_vec_t ns_outport_granted;   // absolute output port numbering
    iport_vec_t valid_spec;
    iport_vec_t spec_ok;
    port_mask_t ns_dest [num_ports];
    port_mask_t sp_dest [num_ports];
    port_mask_t spec_dest [num_ports];   // surviving speculative grants

    assign nonspec_req = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
    assign spec_req = ivc_request & ~ovc_is_assigned;   // credit not checked here

    sw_alloc_stage u_nonspec_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ivc_request      (nonspec_req),
        .dest_port        (dest_port),
        .ivc_granted      (ns_ivc_granted),
        .inport_granted   (ns_inport_granted),
        .granted_dest_port(ns_dest),
        .first_stage_ivc  ()
    );

    sw_alloc_stage u_spec_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ivc_request      (spec_req),
        .dest_port        (dest_port),
        .ivc_granted      (sp_ivc_granted),
        .inport_granted   (),
        .granted_dest_port(sp_dest),
        .first_stage_ivc  (sp_first)
    );

    always_comb begin
        ns_outport_granted = '0;
        for (int p = 0; p < num_ports; p++) begin
            for (int o = 0; o < num_ports; o++) begin
                if (o != p && ns_dest[p][rel_index(p, o)]) begin
                    ns_outport_granted[o] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            // speculative pick must also have won its output VC
            valid_spec[p] = |(sp_first[p*num_vcs +: num_vcs] & ivc_ovc_granted[p*num_vcs +: num_vcs]);
            spec_dest[p] = '0;
            if (valid_spec[p] && !ns_inport_granted[p]) begin
                for (int o = 0; o < num_ports; o++) begin
                    if (o != p && !ns_outport_granted[o]) begin
                        spec_dest[p][rel_index(p, o)] = sp_dest[p][rel_index(p, o)];
                    end
                end
            end
            spec_ok[p] = |spec_dest[p];
            granted_dest_port[p] = ns_dest[p] | spec_dest[p];
            any_sw_grant[p] = ns_inport_granted[p] | spec_ok[p];
            ivc_sw_granted[p*num_vcs +: num_vcs] = ns_ivc_granted[p*num_vcs +: num_vcs] |
                (spec_ok[p] ? sp_ivc_granted[p*num_vcs +: num_vcs] : '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/baseline_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module baseline_allocator
    import alloc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ivc_vec_t   ivc_request,
    input  ivc_vec_t   ovc_is_assigned,
    input  ivc_vec_t   assigned_ovc_not_full,
    input  port_mask_t dest_port [num_ivcs],
    input  vc_mask_t   ovc_request [num_ivcs],     // free output VCs, already masked
    output vc_mask_t   granted_ovc [num_ivcs],
    output ivc_vec_t   ivc_ovc_granted,
    output ivc_vec_t   ovc_allocated,
    output ivc_vec_t   ivc_sw_granted,
    output port_mask_t granted_dest_port [num_ports],
    output iport_vec_t any_sw_grant
);

    vc_alloc u_vc_alloc (
        .clk            (clk),
        .rst_n          (rst_n),
        .ivc_request    (ivc_request),
        .ovc_is_assigned(ovc_is_assigned),
        .dest_port      (dest_port),
        .ovc_request    (ovc_request),
        .granted_ovc    (granted_ovc),
        .ivc_ovc_granted(ivc_ovc_granted),
        .ovc_allocated  (ovc_allocated)
    );

    // VC grants of this cycle validate speculation
    spec_sw_alloc u_spec_sw_alloc (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .ivc_ovc_granted      (ivc_ovc_granted),
        .ivc_sw_granted       (ivc_sw_granted),
        .granted_dest_port    (granted_dest_port),
        .any_sw_grant         (any_sw_grant)
    );

endmodule

`default_nettype wire

// File: test/alloc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module alloc_asserts
    import alloc_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input ivc_vec_t   ivc_request,
    input ivc_vec_t   ovc_is_assigned,
    input ivc_vec_t   assigned_ovc_not_full,
    input port_mask_t dest_port [num_ivcs],
    input vc_mask_t   ovc_request [num_ivcs],
    input vc_mask_t   granted_ovc [num_ivcs],
    input ivc_vec_t   ivc_ovc_granted,
    input ivc_vec_t   ovc_allocated,
    input ivc_vec_t   ivc_sw_granted,
    input port_mask_t granted_dest_port [num_ports]
);

    ivc_vec_t   ovc_union;      // output VCs handed out, rebuilt from the input side
    ivc_vec_t   nonspec_req;
    logic       ovc_double;
    logic       ovc_illegal;
    logic       sw_in_double;
    logic       sw_out_double;
    iport_vec_t out_seen;
    port_mask_t port_dest [num_ports];
    port_mask_t last_dest [num_ports];
    logic [2:0] miss_cnt [num_ports];   // consecutive cycles without the wanted output
    iport_vec_t waiting;
    iport_vec_t starved;

    assign nonspec_req = ivc_request & ovc_is_assigned & assigned_ovc_not_full;

    always_comb begin
        ovc_union = '0;
        ovc_double = 1'b0;
        ovc_illegal = 1'b0;
        for (int o = 0; o < num_ivcs; o++) begin
            for (int i = 0; i < num_ivcs; i++) begin
                if ((i / num_vcs) != (o / num_vcs) && granted_ovc[i][o % num_vcs] &&
                    dest_port[i][rel_index(i / num_vcs, o / num_vcs)]) begin
                    if (ovc_union[o]) begin
                        ovc_double = 1'b1;
                    end
                    ovc_union[o] = 1'b1;
                end
            end
        end
        for (int i = 0; i < num_ivcs; i++) begin
            if (!$onehot0(granted_ovc[i]) || (granted_ovc[i] & ~ovc_request[i]) != '0 ||
                ivc_ovc_granted[i] != (|granted_ovc[i])) begin
                ovc_illegal = 1'b1;
            end
        end
    end

    always_comb begin
        sw_in_double = 1'b0;
        sw_out_double = 1'b0;
        out_seen = '0;
        for (int p = 0; p < num_ports; p++) begin
            if (!$onehot0(ivc_sw_granted[p*num_vcs +: num_vcs])) begin
                sw_in_double = 1'b1;
            end
            for (int o = 0; o < num_ports; o++) begin
                if (o != p && granted_dest_port[p][rel_index(p, o)]) begin
                    if (out_seen[o]) begin
                        sw_out_double = 1'b1;
                    end
                    out_seen[o] = 1'b1;
                end
            end
        end
    end

    // a port whose credited requests all aim at one output must win it within
    // num_other_ports cycles, the round-robin pointer only closes in on it
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            port_dest[p] = '0;
            for (int v = 0; v < num_vcs; v++) begin
                if (nonspec_req[p*num_vcs + v]) begin
                    port_dest[p] = port_dest[p] | dest_port[p*num_vcs + v];
                end
            end
            waiting[p] = $onehot(port_dest[p]) && (granted_dest_port[p] & port_dest[p]) == '0;
            starved[p] = waiting[p] && port_dest[p] == last_dest[p] &&
                         miss_cnt[p] >= 3'(num_other_ports - 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                miss_cnt[p] <= '0;
                last_dest[p] <= '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                last_dest[p] <= port_dest[p];
                if (!waiting[p]) begin
                    miss_cnt[p] <= '0;
                end else if (port_dest[p] == last_dest[p]) begin
                    miss_cnt[p] <= miss_cnt[p] + 3'd1;
                end else begin
                    miss_cnt[p] <= 3'd1;      // new target, count again
                end
            end
        end
    end

    a_ovc_union: assert property (@(posedge clk) disable iff (!rst_n)
        ovc_allocated == ovc_union)
        else $error("ovc_allocated differs from the output VCs handed out");
    a_ovc_single: assert property (@(posedge clk) disable iff (!rst_n) !ovc_double)
        else $error("one output VC given to two input VCs");
    a_ovc_legal: assert property (@(posedge clk) disable iff (!rst_n) !ovc_illegal)
        else $error("granted_ovc not one-hot, outside ovc_request or flag mismatch");
    a_sw_input: assert property (@(posedge clk) disable iff (!rst_n) !sw_in_double)
        else $error("two input VCs of one port won the switch");
    a_sw_output: assert property (@(posedge clk) disable iff (!rst_n) !sw_out_double)
        else $error("one output port granted to two input ports");
    a_spec_backed: assert property (@(posedge clk) disable iff (!rst_n)
        (ivc_sw_granted & ~ovc_is_assigned & ~ivc_ovc_granted) == '0)
        else $error("speculative switch grant without an output VC");
    a_need_request: assert property (@(posedge clk) disable iff (!rst_n)
        ((ivc_sw_granted | ivc_ovc_granted) & ~ivc_request) == '0)
        else $error("grant without a request");
    a_fair: assert property (@(posedge clk) disable iff (!rst_n) starved == '0)
        else $error("input port starved at its output port");

endmodule

`default_nettype wire

// File: test/tb_baseline_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_baseline_allocator
    import alloc_pkg::*;
();

    localparam int random_cycles = 400;

    logic       clk = 1'b0;
    logic       rst_n;
    ivc_vec_t   ivc_request;
    ivc_vec_t   ovc_is_assigned;
    ivc_vec_t   assigned_ovc_not_full;
    port_mask_t dest_port [num_ivcs];
    vc_mask_t   ovc_request [num_ivcs];
    vc_mask_t   granted_ovc [num_ivcs];
    ivc_vec_t   ivc_ovc_granted;
    ivc_vec_t   ovc_allocated;
    ivc_vec_t   ivc_sw_granted;
    port_mask_t granted_dest_port [num_ports];
    iport_vec_t any_sw_grant;
    logic [31:0] lfsr_state;

    always #50 clk = ~clk;

    baseline_allocator u_baseline_allocator (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .ovc_request          (ovc_request),
        .granted_ovc          (granted_ovc),
        .ivc_ovc_granted      (ivc_ovc_granted),
        .ovc_allocated        (ovc_allocated),
        .ivc_sw_granted       (ivc_sw_granted),
        .granted_dest_port    (granted_dest_port),
        .any_sw_grant         (any_sw_grant)
    );

    bind baseline_allocator alloc_asserts u_alloc_asserts (
        .clk                  (clk),
        .rst_n                (rst_n),
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .dest_port            (dest_port),
        .ovc_request          (ovc_request),
        .granted_ovc          (granted_ovc),
        .ivc_ovc_granted      (ivc_ovc_granted),
        .ovc_allocated        (ovc_allocated),
        .ivc_sw_granted       (ivc_sw_granted),
        .granted_dest_port    (granted_dest_port)
    );

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic clear_inputs();
        ivc_request = '0;
        ovc_is_assigned = '0;
        assigned_ovc_not_full = '0;
        for (int i = 0; i < num_ivcs; i++) begin
            dest_port[i] = '0;
            ovc_request[i] = '0;
        end
    endtask

    task automatic set_flit(input int ivc, input logic assigned, input logic credited,
                            input int out_port, input vc_mask_t ovcs);
        ivc_request[ivc] = 1'b1;
        ovc_is_assigned[ivc] = assigned;
        assigned_ovc_not_full[ivc] = credited;
        dest_port[ivc] = port_mask_t'(1) << rel_index(ivc / num_vcs, out_port);
        ovc_request[ivc] = ovcs;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "directed check failed");
        end
    endtask

    task automatic check_idle();
        logic [31:0] ovc_or;
        logic [31:0] dest_or;
        ovc_or = '0;
        dest_or = '0;
        for (int i = 0; i < num_ivcs; i++) begin
            ovc_or = ovc_or | 32'(granted_ovc[i]);
        end
        for (int p = 0; p < num_ports; p++) begin
            dest_or = dest_or | 32'(granted_dest_port[p]);
        end
        check_value("idle granted_ovc", 0, ovc_or);
        check_value("idle ivc_ovc_granted", 0, 32'(ivc_ovc_granted));
        check_value("idle ovc_allocated", 0, 32'(ovc_allocated));
        check_value("idle ivc_sw_granted", 0, 32'(ivc_sw_granted));
        check_value("idle granted_dest_port", 0, dest_or);
        check_value("idle any_sw_grant", 0, 32'(any_sw_grant));
    endtask

    // one-hot destinations and output VC requests inside a random free set
    task automatic drive_random();
        ivc_vec_t free_ovcs;
        int rel;
        int abs_port;
        free_ovcs = ivc_vec_t'(rand_bits(num_ivcs));
        for (int i = 0; i < num_ivcs; i++) begin
            ivc_request[i] = lfsr_bit();
            ovc_is_assigned[i] = lfsr_bit();
            assigned_ovc_not_full[i] = lfsr_bit();
            rel = int'(rand_bits(2)) % num_other_ports;
            abs_port = (rel < i / num_vcs) ? rel : rel + 1;
            dest_port[i] = port_mask_t'(1) << rel;
            ovc_request[i] = vc_mask_t'(rand_bits(num_vcs)) &
                             free_ovcs[abs_port*num_vcs +: num_vcs];
        end
    endtask

    initial begin
        lfsr_state = 32'h4fcebe46;
        rst_n = 1'b0;
        clear_inputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_idle();

        // lone credited flit from port 1 vc 0 to port 3
        @(negedge clk);
        set_flit(2, 1'b1, 1'b1, 3, '0);
        #1;
        check_value("lone ivc_sw_granted", 32'(1 << 2), 32'(ivc_sw_granted));
        check_value("lone granted_dest_port", 32'(1 << rel_index(1, 3)),
                    32'(granted_dest_port[1]));
        check_value("lone any_sw_grant", 32'b00010, 32'(any_sw_grant));
        @(negedge clk);
        assigned_ovc_not_full[2] = 1'b0;     // no credit means no grant
        #1;
        check_value("no credit ivc_sw_granted", 0, 32'(ivc_sw_granted));
        check_value("no credit any_sw_grant", 0, 32'(any_sw_grant));

        // head VC on port 2 against a credited flit from port 0 for port 3
        @(negedge clk);
        clear_inputs();
        set_flit(0, 1'b1, 1'b1, 3, '0);
        set_flit(4, 1'b0, 1'b0, 3, 2'b01);
        #1;
        check_value("conflict ivc_sw_granted", 32'(1 << 0), 32'(ivc_sw_granted));
        check_value("conflict any_sw_grant", 32'b00001, 32'(any_sw_grant));

        // alone with a free output VC the head wins VC and switch in one cycle
        @(negedge clk);
        clear_inputs();
        set_flit(4, 1'b0, 1'b0, 3, 2'b01);
        #1;
        check_value("head ivc_sw_granted", 32'(1 << 4), 32'(ivc_sw_granted));
        check_value("head ivc_ovc_granted", 32'(1 << 4), 32'(ivc_ovc_granted));
        check_value("head granted_ovc", 32'b01, 32'(granted_ovc[4]));
        check_value("head ovc_allocated", 32'(1 << (3 * num_vcs)), 32'(ovc_allocated));
        check_value("head granted_dest_port", 32'(1 << rel_index(2, 3)),
                    32'(granted_dest_port[2]));

        // ports 0 and 1 both hold port 2
        @(negedge clk);
        clear_inputs();
        set_flit(0, 1'b1, 1'b1, 2, '0);
        set_flit(2, 1'b1, 1'b1, 2, '0);
        repeat (6 * num_other_ports) @(negedge clk);

        for (int n = 0; n < random_cycles; n++) begin
            @(negedge clk);
            drive_random();
        end

        @(negedge clk);
        clear_inputs();
        #1;
        check_idle();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/alloc_pkg.sv
hdl/rr_arbiter.sv
vc_alloc/vc_alloc.sv
sw_alloc/sw_alloc_stage.sv
sw_alloc/spec_sw_alloc.sv
hdl/baseline_allocator.sv
test/alloc_asserts.sv
test/tb_baseline_allocator.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_baseline_allocator
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
